//--- hdl/isaPkg.sv
// isaPkg: data width, register index width, ALU ops, conditions, jump kinds, result sources
package isaPkg;

   // data and address word width
   localparam int dataW = 16;
   // eight architectural registers
   localparam int regSelW = 3;

   // ALU operation, applied after the optional operand inversions
   typedef enum logic [3:0] {
      aluAdd, aluAnd, aluOr, aluXor,
      aluSll, aluSrl, aluRol, aluPassB
   } aluOpE;

   // condition field
   // eqz..gez compare operand A against zero and steer the branch
   // seq..sco are set ops and turn the condition into a 0/1 result
   typedef enum logic [3:0] {
      brNone, brEqz, brNez, brLtz, brGez,
      brSeq, brSlt, brSle, brSco
   } brchE;

   // jump kind: pc relative target or ALU computed register jump
   typedef enum logic [1:0] {
      jmpNone, jmpRel, jmpReg
   } jmpE;

   // where the written back value comes from
   typedef enum logic [1:0] {
      resAlu, resMem, resPc, resImm
   } resSrcE;

endpackage

//--- hdl/pipePkg.sv
// pipePkg: issued op, EX/MEM and MEM/WB stage registers, retire record
package pipePkg;

   // decoded op as it arrives on the issue stream
   typedef struct packed {
      // set by the issuer along with opValid
      logic                            valid;
      logic [isaPkg::regSelW-1:0]      srcA;
      logic [isaPkg::regSelW-1:0]      srcB;
      logic [isaPkg::regSelW-1:0]      dst;
      logic                            wrEn;
      isaPkg::aluOpE                   aluOp;
      logic                            invA;
      logic                            invB;
      logic                            cin;
      isaPkg::brchE                    brch;
      isaPkg::jmpE                     jmp;
      isaPkg::resSrcE                  resSrc;
      logic                            memWr;
      // ALU operand B is imm instead of register B
      logic                            immSel;
      logic [isaPkg::dataW-1:0]        imm;
      logic [isaPkg::dataW-1:0]        incPc;
   } issueOpT;

   // EX/MEM, value is the memory address for loads and stores
   typedef struct packed {
      logic                            valid;
      logic [isaPkg::regSelW-1:0]      dst;
      logic                            wrEn;
      isaPkg::resSrcE                  resSrc;
      logic [isaPkg::dataW-1:0]        value;
      logic [isaPkg::dataW-1:0]        storeData;
      logic                            memWr;
      logic [isaPkg::dataW-1:0]        nextPc;
   } exMemT;

   // MEM/WB, holds the final result
   typedef struct packed {
      logic                            valid;
      logic [isaPkg::regSelW-1:0]      dst;
      logic                            wrEn;
      logic [isaPkg::dataW-1:0]        result;
      logic [isaPkg::dataW-1:0]        nextPc;
   } memWbT;

   typedef struct packed {
      logic [isaPkg::regSelW-1:0]      dst;
      logic                            wrEn;
      logic [isaPkg::dataW-1:0]        result;
      logic [isaPkg::dataW-1:0]        nextPc;
   } retireT;

endpackage

//--- hdl/regFile.sv
// regFile: eight-entry register file, two read ports, one write port with bypass
`timescale 1ns/1ps
`default_nettype none
module regFile (
   input  wire logic                          clk,
   input  wire logic                          rst,
   input  wire logic [isaPkg::regSelW-1:0]    rdAddrA,
   input  wire logic [isaPkg::regSelW-1:0]    rdAddrB,
   output logic      [isaPkg::dataW-1:0]      rdDataA,
   output logic      [isaPkg::dataW-1:0]      rdDataB,
   input  wire logic                          wrEn,
   input  wire logic [isaPkg::regSelW-1:0]    wrAddr,
   input  wire logic [isaPkg::dataW-1:0]      wrData
);

   logic [isaPkg::dataW-1:0] regs [2**isaPkg::regSelW];

   // contents survive reset, only writes are blocked while it is held
   always_ff @(posedge clk) begin
      if (wrEn && !rst) begin
         regs[wrAddr] <= wrData;
      end
   end

   // same-cycle write shows up on the read ports
   assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
   assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule
`default_nettype wire

//--- hdl/alu.sv
// alu: 16-bit ALU with operand inversion, carry-in and add-path flags
`timescale 1ns/1ps
`default_nettype none
module alu (
   input  wire logic [isaPkg::dataW-1:0]   inA,
   input  wire logic [isaPkg::dataW-1:0]   inB,
   input  wire logic                       cin,
   input  wire isaPkg::aluOpE              op,
   input  wire logic                       invA,
   input  wire logic                       invB,
   output logic      [isaPkg::dataW-1:0]   result,
   output logic                            zero,
   output logic                            sign,
   output logic                            ofl,
   output logic                            carry
);

   logic [isaPkg::dataW-1:0]   opA;
   logic [isaPkg::dataW-1:0]   opB;
   logic [isaPkg::dataW-1:0]   sum;
   logic [2*isaPkg::dataW-1:0] dbl;
   logic [3:0]                 shAmt;

   assign opA = invA ? ~inA : inA;
   assign opB = invB ? ~inB : inB;

   // add path, always active since set and branch ops read its flags
   assign {carry, sum} = opA + opB + cin;
   assign zero  = (sum == '0);
   assign sign  = sum[isaPkg::dataW-1];
   // signed overflow: like signs in, other sign out
   assign ofl   = (opA[isaPkg::dataW-1] == opB[isaPkg::dataW-1]) &&
                  (sum[isaPkg::dataW-1] != opA[isaPkg::dataW-1]);

   // shift amount from low bits of B
   assign shAmt = opB[3:0];
   // rotate: upper half of the doubled word after the left shift
   assign dbl   = {opA, opA} << shAmt;

   always_comb begin
      case (op)
         isaPkg::aluAdd:   result = sum;
         isaPkg::aluAnd:   result = opA & opB;
         isaPkg::aluOr:    result = opA | opB;
         isaPkg::aluXor:   result = opA ^ opB;
         isaPkg::aluSll:   result = opA << shAmt;
         isaPkg::aluSrl:   result = opA >> shAmt;
         isaPkg::aluRol:   result = dbl[2*isaPkg::dataW-1:isaPkg::dataW];
         default:          result = opB;
      endcase
   end

endmodule
`default_nettype wire

//--- hdl/execute.sv
// execute: operand forwarding, ALU, condition evaluation, PC target and next-PC select
`timescale 1ns/1ps
`default_nettype none
module execute (
   input  wire pipePkg::issueOpT           op,
   input  wire logic [isaPkg::dataW-1:0]   regA,
   input  wire logic [isaPkg::dataW-1:0]   regB,
   input  wire pipePkg::exMemT             exMem,
   input  wire pipePkg::memWbT             memWb,
   output pipePkg::exMemT                  nextExMem
);

   logic [isaPkg::dataW-1:0] fwdA, fwdB, aluB, aluRes;
   logic [isaPkg::dataW-1:0] pcTarget, nextPc, staged;
   logic zero, sign, ofl, carry;
   logic zeroCmp, setOp, cond, taken;

   // youngest valid writer wins, EX/MEM never holds load data here
   function automatic logic [isaPkg::dataW-1:0] fwdSel(
      input logic [isaPkg::regSelW-1:0] src,
      input logic [isaPkg::dataW-1:0]   regVal
   );
      if (exMem.valid && exMem.wrEn && exMem.dst == src)
         return exMem.value;
      if (memWb.valid && memWb.wrEn && memWb.dst == src)
         return memWb.result;
      return regVal;
   endfunction

   // stage registers are read inside fwdSel
   always_comb begin
      fwdA = fwdSel(op.srcA, regA);
      fwdB = fwdSel(op.srcB, regB);
   end

   assign zeroCmp = op.brch inside {isaPkg::brEqz, isaPkg::brNez, isaPkg::brLtz, isaPkg::brGez};
   assign setOp   = op.brch inside {isaPkg::brSeq, isaPkg::brSlt, isaPkg::brSle, isaPkg::brSco};

   // zero compares add nothing to A so the flags describe A itself
   assign aluB = zeroCmp ? '0 : (op.immSel ? op.imm : fwdB);

   alu alu_i (
      .inA(fwdA), .inB(aluB), .cin(op.cin), .op(op.aluOp), .invA(op.invA), .invB(op.invB),
      .result(aluRes), .zero(zero), .sign(sign), .ofl(ofl), .carry(carry)
   );

   always_comb begin
      case (op.brch)
         isaPkg::brEqz, isaPkg::brSeq: cond = zero;
         isaPkg::brNez:                cond = !zero;
         isaPkg::brLtz:                cond = sign;
         isaPkg::brGez:                cond = !sign;
         // signed less than from the subtract flags
         isaPkg::brSlt:                cond = sign ^ ofl;
         isaPkg::brSle:                cond = (sign ^ ofl) | zero;
         isaPkg::brSco:                cond = carry;
         default:                      cond = 1'b0;
      endcase
   end

   assign taken    = zeroCmp && cond;
   assign pcTarget = op.incPc + op.imm;

   always_comb begin
      case (op.jmp)
         isaPkg::jmpRel: nextPc = pcTarget;
         isaPkg::jmpReg: nextPc = aluRes;
         default:        nextPc = taken ? pcTarget : op.incPc;
      endcase
      // loads keep the address in value, memStage swaps in the data
      case (op.resSrc)
         isaPkg::resPc:  staged = op.incPc;
         isaPkg::resImm: staged = op.imm;
         isaPkg::resMem: staged = aluRes;
         default:        staged = setOp ? {{(isaPkg::dataW-1){1'b0}}, cond} : aluRes;
      endcase
   end

   assign nextExMem = '{valid: op.valid, dst: op.dst, wrEn: op.wrEn, resSrc: op.resSrc,
                        value: staged, storeData: fwdB, memWr: op.memWr, nextPc: nextPc};

endmodule
`default_nettype wire

//--- hdl/memStage.sv
// memStage: data memory with synchronous write, combinational read, result select
`timescale 1ns/1ps
`default_nettype none
module memStage #(
   parameter int memDepthLog2 = 8
) (
   input  wire logic            clk,
   input  wire pipePkg::exMemT  exMem,
   output pipePkg::memWbT       memWb
);

   logic [isaPkg::dataW-1:0] mem [2**memDepthLog2];
   logic [memDepthLog2-1:0]  addr;
   logic                     isLoad;

   // word addressed, upper address bits ignored
   assign addr   = exMem.value[memDepthLog2-1:0];
   assign isLoad = (exMem.resSrc == isaPkg::resMem);

   // valid here is already qualified with the stage advance
   always_ff @(posedge clk) begin
      if (exMem.valid && exMem.memWr) begin
         mem[addr] <= exMem.storeData;
      end
   end

   assign memWb.valid  = exMem.valid;
   assign memWb.dst    = exMem.dst;
   assign memWb.wrEn   = exMem.wrEn;
   assign memWb.nextPc = exMem.nextPc;
   // load data, else the value staged in execute
   assign memWb.result = isLoad ? mem[addr] : exMem.value;

endmodule
`default_nettype wire

//--- hdl/hazardCtrl.sv
// hazardCtrl: FSM for startup, load-use stall and retire back-pressure
`timescale 1ns/1ps
`default_nettype none
module hazardCtrl (
   input  wire logic                         clk,
   input  wire logic                         rst,
   input  wire logic                         opValid,
   input  wire logic [isaPkg::regSelW-1:0]   opSrcA,
   input  wire logic [isaPkg::regSelW-1:0]   opSrcB,
   input  wire pipePkg::exMemT               exMem,
   input  wire logic                         retireValid,
   input  wire logic                         retireReady,
   output logic                              opReady,
   output logic                              exEnable,
   output logic                              wbEnable,
   output logic                              insertBubble
);

   typedef enum logic [1:0] {stStartup, stRun, stLoadStall} stateE;
   stateE state, stateNext;
   logic  frozen, loadUse;

   // retire word not taken, whole pipe holds
   assign frozen  = retireValid && !retireReady;
   // load data only exists after MEM, so a dependent op waits one cycle
   assign loadUse = opValid && exMem.valid && exMem.wrEn &&
                    exMem.resSrc == isaPkg::resMem &&
                    (exMem.dst == opSrcA || exMem.dst == opSrcB);

   always_ff @(posedge clk) begin
      if (rst) state <= stStartup;
      else     state <= stateNext;
   end

   always_comb begin
      stateNext    = state;
      opReady      = 1'b0;
      exEnable     = !frozen;
      wbEnable     = !frozen;
      insertBubble = 1'b1;
      case (state)
         stStartup: begin
            // one idle cycle out of reset
            stateNext = stRun;
         end
         stRun: begin
            if (!frozen && loadUse) begin
               stateNext = stLoadStall;
            end else begin
               opReady      = !frozen;
               insertBubble = !opValid;
            end
         end
         default: begin
            // bubble went in, load now sits in MEM/WB for forwarding
            opReady      = !frozen;
            insertBubble = !opValid;
            if (!frozen) stateNext = stRun;
         end
      endcase
   end

endmodule
`default_nettype wire

//--- hdl/backEnd.sv
// backEnd: top level with stage registers, register file, execute, memory and hazard control
`timescale 1ns/1ps
`default_nettype none
module backEnd #(
   parameter int memDepthLog2 = 8
) (
   input  wire logic               clk,
   input  wire logic               rst,
   input  wire pipePkg::issueOpT   opIn,
   input  wire logic               opValid,
   output logic                    opReady,
   output pipePkg::retireT         retire,
   output logic                    retireValid,
   input  wire logic               retireReady
);

   pipePkg::exMemT exMem, exMemNext, exMemGo;
   pipePkg::memWbT memWb, memWbNext;
   logic [isaPkg::dataW-1:0] regA, regB;
   logic exEnable, wbEnable, insertBubble, rfWrEn;

   // register write coincides with the retire handshake
   assign rfWrEn = wbEnable && memWb.valid && memWb.wrEn;

   regFile regFile_i (
      .clk(clk), .rst(rst), .rdAddrA(opIn.srcA), .rdAddrB(opIn.srcB),
      .rdDataA(regA), .rdDataB(regB),
      .wrEn(rfWrEn), .wrAddr(memWb.dst), .wrData(memWb.result)
   );

   execute execute_i (
      .op(opIn), .regA(regA), .regB(regB), .exMem(exMem), .memWb(memWb),
      .nextExMem(exMemNext)
   );

   // stores only land on the edge where EX/MEM moves on
   always_comb begin
      exMemGo       = exMem;
      exMemGo.valid = exMem.valid && wbEnable;
   end

   memStage #(.memDepthLog2(memDepthLog2)) memStage_i (
      .clk(clk), .exMem(exMemGo), .memWb(memWbNext)
   );

   hazardCtrl hazardCtrl_i (
      .clk(clk), .rst(rst), .opValid(opValid), .opSrcA(opIn.srcA), .opSrcB(opIn.srcB),
      .exMem(exMem), .retireValid(retireValid), .retireReady(retireReady),
      .opReady(opReady), .exEnable(exEnable), .wbEnable(wbEnable),
      .insertBubble(insertBubble)
   );

   // stage registers
   always_ff @(posedge clk) begin
      if (rst) begin
         exMem <= '0;
         memWb <= '0;
      end else begin
         if (exEnable) exMem <= insertBubble ? '0 : exMemNext;
         if (wbEnable) memWb <= memWbNext;
      end
   end

   // retire stream straight from MEM/WB
   assign retireValid = memWb.valid;
   assign retire      = '{dst: memWb.dst, wrEn: memWb.wrEn, result: memWb.result,
                          nextPc: memWb.nextPc};

endmodule
`default_nettype wire

//--- verif/clockGen.sv
// clockGen: testbench clock and synchronous reset held for the first cycles
`timescale 1ns/1ps
module clockGen #(
   parameter int periodNs    = 8,
   parameter int resetCycles = 3
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(periodNs / 2) clk = ~clk;
   end

   // reset seen high on the first resetCycles rising edges
   initial begin
      rst = 1'b1;
      repeat (resetCycles) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

//--- verif/backEndTb.sv
// backEndTb: random op stream, in-order reference model, compare task, watchdog and verdict
`timescale 1ns/1ps
module backEndTb;

   localparam int memDepthLog2 = 8;
   localparam int numOps       = 408;
   localparam int cyclesPerOp  = 20;

   typedef logic [isaPkg::dataW-1:0] wordT;

   logic clk;
   logic rst;
   pipePkg::issueOpT opIn        = '0;
   logic             opValid     = 1'b0;
   logic             retireReady = 1'b0;
   logic             opReady;
   logic             retireValid;
   pipePkg::retireT  retire;

   // reference model state
   wordT             regs [8];
   wordT             mem [2**memDepthLog2];
   bit               storedMark [2**memDepthLog2];
   int               storedQ[$];
   int               lastStore = 0;
   pipePkg::retireT  expQ[$];
   pipePkg::retireT  want;
   wordT             pc = '0;
   logic [2:0]       recent [3] = '{3'd0, 3'd0, 3'd0};

   // stimulus bookkeeping
   integer           seed = 32'hcfec;
   int               genCount = 0;
   int               accepted = 0;
   int               retired = 0;
   int               sinceReset = 0;
   logic             havePending = 1'b0;
   logic             opFire = 1'b0;
   logic             retFire = 1'b0;
   pipePkg::issueOpT curOp = '0;

   clockGen clockGen_i (.clk(clk), .rst(rst));

   backEnd #(.memDepthLog2(memDepthLog2)) backEnd_i (
      .clk(clk), .rst(rst), .opIn(opIn), .opValid(opValid), .opReady(opReady),
      .retire(retire), .retireValid(retireValid), .retireReady(retireReady)
   );

   task automatic abortRun(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic checkEq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
      if (expected !== actual) begin
         abortRun($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
      end
   endtask

   // ALU as the ISA defines it, operands already inverted
   function automatic wordT aluModel(input isaPkg::aluOpE op, input wordT x, input wordT y,
                                     input logic c);
      logic [4:0] s;
      s = {1'b0, y[3:0]};
      case (op)
         isaPkg::aluAdd: return x + y + wordT'(c);
         isaPkg::aluAnd: return x & y;
         isaPkg::aluOr:  return x | y;
         isaPkg::aluXor: return x ^ y;
         isaPkg::aluSll: return x << s;
         isaPkg::aluSrl: return x >> s;
         // rotate by zero leaves x, the right shift then drops everything
         isaPkg::aluRol: return (x << s) | (x >> (5'd16 - s));
         default:        return y;
      endcase
   endfunction

   // executes one accepted op in order and queues its retire word
   task automatic modelStep(input pipePkg::issueOpT op);
      wordT        a, b, y, aluV, res, nxt;
      logic [16:0] wide;
      logic        cond, zeroCmp, setOp;
      int          idx;
      a = regs[op.srcA];
      b = regs[op.srcB];
      zeroCmp = op.brch inside {isaPkg::brEqz, isaPkg::brNez, isaPkg::brLtz, isaPkg::brGez};
      setOp = op.brch inside {isaPkg::brSeq, isaPkg::brSlt, isaPkg::brSle, isaPkg::brSco};
      // branches compare A against zero
      y = zeroCmp ? '0 : (op.immSel ? op.imm : b);
      aluV = aluModel(op.aluOp, op.invA ? ~a : a, op.invB ? ~y : y, op.cin);
      wide = {1'b0, a} + {1'b0, y};
      case (op.brch)
         isaPkg::brEqz: cond = (a == '0);
         isaPkg::brNez: cond = (a != '0);
         isaPkg::brLtz: cond = a[15];
         isaPkg::brGez: cond = !a[15];
         isaPkg::brSeq: cond = (a == y);
         isaPkg::brSlt: cond = ($signed(a) < $signed(y));
         isaPkg::brSle: cond = ($signed(a) <= $signed(y));
         isaPkg::brSco: cond = wide[16];
         default:       cond = 1'b0;
      endcase
      idx = int'(aluV[memDepthLog2-1:0]);
      case (op.resSrc)
         isaPkg::resPc:  res = op.incPc;
         isaPkg::resImm: res = op.imm;
         isaPkg::resMem: res = mem[idx];
         default:        res = setOp ? wordT'(cond) : aluV;
      endcase
      case (op.jmp)
         isaPkg::jmpRel: nxt = op.incPc + op.imm;
         isaPkg::jmpReg: nxt = aluV;
         default:        nxt = (zeroCmp && cond) ? op.incPc + op.imm : op.incPc;
      endcase
      // store data always comes from register B
      if (op.memWr) begin
         mem[idx] = b;
         lastStore = idx;
         if (!storedMark[idx]) begin
            storedMark[idx] = 1'b1;
            storedQ.push_back(idx);
         end
      end
      if (op.wrEn) regs[op.dst] = res;
      pc = nxt;
      want = '{dst: op.dst, wrEn: op.wrEn, result: res, nextPc: nxt};
      expQ.push_back(want);
   endtask

   // sources lean toward the last few destinations to hit forwarding
   function automatic logic [2:0] pickSrc();
      if ({$random(seed)} % 10 < 6) return recent[{$random(seed)} % 3];
      return 3'($random(seed));
   endfunction

   // first eight ops load every register with an immediate
   function automatic pipePkg::issueOpT genOp(input int n);
      pipePkg::issueOpT op;
      int               kind;
      logic [7:0]       idx;
      op = '0;
      op.valid = 1'b1;
      op.srcA = pickSrc();
      op.srcB = pickSrc();
      op.dst = (n < 8) ? 3'(n) : 3'($random(seed));
      op.imm = 16'($random(seed));
      op.incPc = pc + 16'd2;
      op.aluOp = isaPkg::aluAdd;
      op.wrEn = 1'b1;
      kind = (n < 8) ? 99 : {$random(seed)} % 100;
      // no word written yet, load becomes a store
      if (kind >= 80 && kind < 92 && storedQ.size() == 0) kind = 70;
      if (kind < 35) begin
         op.aluOp = isaPkg::aluOpE'({$random(seed)} % 8);
         op.immSel = 1'($random(seed));
         op.invA = ({$random(seed)} % 8 == 0);
         op.invB = ({$random(seed)} % 8 == 0);
         op.cin = 1'($random(seed));
      end else if (kind < 50) begin
         // set ops subtract, except carry-out which adds
         op.brch = isaPkg::brchE'(5 + {$random(seed)} % 4);
         op.immSel = 1'($random(seed));
         op.invB = (op.brch != isaPkg::brSco);
         op.cin = op.invB;
      end else if (kind < 60) begin
         op.brch = isaPkg::brchE'(1 + {$random(seed)} % 4);
         op.wrEn = 1'b0;
      end else if (kind < 68) begin
         // jump, or jump-and-link when wrEn stays set
         op.jmp = $random(seed) & 1 ? isaPkg::jmpRel : isaPkg::jmpReg;
         op.immSel = 1'b1;
         op.resSrc = isaPkg::resPc;
         op.wrEn = 1'($random(seed));
      end else if (kind < 80) begin
         op.memWr = 1'b1;
         op.immSel = 1'b1;
         op.wrEn = 1'b0;
      end else if (kind < 92) begin
         // half the loads go back to the newest store
         idx = ($random(seed) & 1) ? 8'(lastStore) : 8'(storedQ[{$random(seed)} % storedQ.size()]);
         op.imm = {8'($random(seed)), idx} - regs[op.srcA];
         op.immSel = 1'b1;
         op.resSrc = isaPkg::resMem;
      end else begin
         op.resSrc = isaPkg::resImm;
      end
      if (op.wrEn) begin
         recent[2] = recent[1];
         recent[1] = recent[0];
         recent[0] = op.dst;
      end
      return op;
   endfunction

   // sample handshakes and the retire word midway through the cycle
   always @(negedge clk) begin
      opFire = opValid && opReady;
      retFire = retireValid && retireReady;
      if (!rst) begin
         sinceReset++;
         if (sinceReset == 1) checkEq("opReady after reset", 32'd0, 32'(opReady));
         if (retireValid && accepted == 0) begin
            abortRun("retireValid rose before any op was accepted");
         end else if (retFire && expQ.size() == 0) begin
            abortRun("retire word came out with no accepted op behind it");
         end else if (retFire) begin
            want = expQ.pop_front();
            checkEq($sformatf("op %0d dst", retired), 32'(want.dst), 32'(retire.dst));
            checkEq($sformatf("op %0d wrEn", retired), 32'(want.wrEn), 32'(retire.wrEn));
            checkEq($sformatf("op %0d result", retired), 32'(want.result), 32'(retire.result));
            checkEq($sformatf("op %0d nextPc", retired), 32'(want.nextPc), 32'(retire.nextPc));
            retired++;
         end
      end
   end

   // model the op taken on this edge, then present the next one
   always @(posedge clk) begin
      if (rst) begin
         opValid <= 1'b0;
         retireReady <= 1'b0;
      end else begin
         if (opFire) begin
            modelStep(curOp);
            accepted++;
            havePending = 1'b0;
         end
         // idle gaps now and then, an offered op is held until taken
         if (!havePending && genCount < numOps && {$random(seed)} % 10 < 9) begin
            curOp = genOp(genCount);
            genCount++;
            havePending = 1'b1;
         end
         opIn <= curOp;
         opValid <= havePending;
         retireReady <= ({$random(seed)} % 10) < 7;
      end
   end

   initial begin
      repeat (cyclesPerOp * numOps) @(posedge clk);
      abortRun($sformatf("pipeline stalled, %0d of %0d ops retired in the time allowed",
                         retired, numOps));
   end

   initial begin
      wait (retired == numOps);
      // extra cycles catch a duplicated retire word, the pipe must be empty after them
      repeat (10) @(posedge clk);
      if (!retireValid) begin
         $display("TEST OK");
         $finish;
      end else begin
         $display("TEST FAILED");
         $fatal(1, "retire word still offered after the last op retired");
      end
   end

endmodule

//--- backEnd.f
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/regFile.sv
hdl/alu.sv
hdl/execute.sv
hdl/memStage.sv
hdl/hazardCtrl.sv
hdl/backEnd.sv
verif/clockGen.sv
verif/backEndTb.sv

//--- run.sh
#!/bin/sh
# build and run the backEnd testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module backEndTb -f backEnd.f -o backEndSim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/backEndSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TEST FAILED" sim.log; then
   exit 1
fi
exit 0
